//--- Bender.yml
package:
  name: board_top

sources:
  - include_dirs:
      - design
    files:
      - design/board_pkg.sv
      - design/uart_rx.sv
      - design/rx_fifo.sv
      - design/key_debounce.sv
      - design/seg_display.sv
      - design/board_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/board_tb.sv

//--- board_top.f
+incdir+design
design/board_pkg.sv
design/uart_rx.sv
design/rx_fifo.sv
design/key_debounce.sv
design/seg_display.sv
design/board_top.sv
test/board_tb.sv

//--- design/board_defines.svh
// board-wide timing constants and sizes
// values kept small for short simulation runs
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// clock cycles per uart bit
`define BIT_CYCLES 16

// cycles a key must hold still before it counts
`define DEBOUNCE_CYCLES 8

// cycles each display digit stays lit
// eight digits make one scan frame
`define DIGIT_CYCLES 4

// fifo holds 2**3 records
`define FIFO_DEPTH_LOG2 3

// push keys on the board
`define KEY_COUNT 2

// key roles
`define KEY_CLEAR 0
`define KEY_FREEZE 1

`endif

//--- design/board_pkg.sv
// record type for received bytes
// status word seen as bytes or as hex nibbles
`default_nettype none

package board_pkg;

	// one received byte with its stop-bit check
	typedef struct packed {
		logic [7:0] data;
		logic       frame_err;
	} rx_byte_t;

	// status bytes, count in the top byte
	typedef struct packed {
		logic [7:0] rx_count;
		logic [7:0] err_count;
		logic [7:0] prev_byte;
		logic [7:0] last_byte;
	} disp_bytes_t;

	// written as bytes, scanned as nibbles
	// nib[0] is the least significant nibble
	typedef union packed {
		disp_bytes_t     bytes;
		logic [7:0][3:0] nib;
	} disp_word_u;

endpackage

`default_nettype wire

//--- design/board_top.sv
// board top level
// uart receiver into fifo, fifo drained by the display unit
// keys debounced for clear and freeze
`timescale 1ns/1ns
`default_nettype none
`include "board_defines.svh"

module board_top (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  uart_rx_port,
	input  logic [`KEY_COUNT-1:0] key_in,
	output logic [7:0]            seg_number,
	output logic [7:0]            seg_choice,
	output logic [7:0]            led
);
	import board_pkg::*;

	rx_byte_t              rx_rec;
	logic                  rx_valid;
	rx_byte_t              fifo_head;
	logic                  fifo_empty;
	logic                  disp_pop;
	logic [`KEY_COUNT-1:0] key_level;
	logic [`KEY_COUNT-1:0] key_press;

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (uart_rx_port),
		.rx_byte   (rx_rec),
		.rx_valid  (rx_valid)
	);

	// full left open, overflow bytes simply drop
	rx_fifo u_rx_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr        (rx_valid),
		.wr_data   (rx_rec),
		.pop       (disp_pop),
		.head      (fifo_head),
		.empty     (fifo_empty),
		.full      ()
	);

	key_debounce u_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_level (key_level),
		.key_press (key_press)
	);

	seg_display u_seg_display (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.head       (fifo_head),
		.empty      (fifo_empty),
		.pop        (disp_pop),
		.key_level  (key_level),
		.key_press  (key_press),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.led        (led)
	);

endmodule

`default_nettype wire

//--- design/key_debounce.sv
// push key conditioning
// per key synchronizer, stability counter and press edge
`timescale 1ns/1ns
`default_nettype none
`include "board_defines.svh"

module key_debounce (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [`KEY_COUNT-1:0] key_in,
	output logic [`KEY_COUNT-1:0] key_level,
	output logic [`KEY_COUNT-1:0] key_press
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	genvar k;
	generate
		for (k = 0; k < `KEY_COUNT; k++) begin : g_key
			logic             sync_a;
			logic             sync_b;
			logic [CNT_W-1:0] stable_cnt;
			logic             settled;
			logic             level_q;
			logic             press_q;

			// new value held long enough
			assign settled = (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1));

			// keys are active low, flip to pressed-high
			always_ff @(posedge sys_clk or negedge sys_rst_n) begin
				if (!sys_rst_n) begin
					sync_a <= 1'b0;
					sync_b <= 1'b0;
				end else begin
					sync_a <= ~key_in[k];
					sync_b <= sync_a;
				end
			end

			always_ff @(posedge sys_clk or negedge sys_rst_n) begin
				if (!sys_rst_n) begin
					stable_cnt <= '0;
					level_q    <= 1'b0;
					press_q    <= 1'b0;
				end else begin
					press_q <= 1'b0;
					// any bounce back restarts the count
					if (sync_b == level_q) begin
						stable_cnt <= '0;
					end else if (settled) begin
						stable_cnt <= '0;
						level_q    <= sync_b;
						// rising edge of the clean level
						press_q    <= sync_b;
					end else begin
						stable_cnt <= stable_cnt + 1'b1;
					end
				end
			end

			assign key_level[k] = level_q;
			assign key_press[k] = press_q;
		end
	endgenerate

endmodule

`default_nettype wire

//--- design/rx_fifo.sv
// show-ahead fifo of received records
// head read combinationally, full and empty from wide pointers
`timescale 1ns/1ns
`default_nettype none
`include "board_defines.svh"

module rx_fifo (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                wr,
	input  board_pkg::rx_byte_t wr_data,
	input  logic                pop,
	output board_pkg::rx_byte_t head,
	output logic                empty,
	output logic                full
);
	import board_pkg::*;

	localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;
	localparam int AW    = `FIFO_DEPTH_LOG2;

	rx_byte_t    mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_wr;
	logic        do_pop;

	// writes into a full fifo are lost
	assign do_wr  = wr & ~full;
	assign do_pop = pop & ~empty;

	// extra pointer bit tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// oldest record always on the head
	assign head = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge sys_clk) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

endmodule

`default_nettype wire

//--- design/seg_display.sv
// status counters fed by frame-aligned pops
// eight digit scanner with hex to segment table
// led mirrors the latest byte
`timescale 1ns/1ns
`default_nettype none
`include "board_defines.svh"

module seg_display (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  board_pkg::rx_byte_t   head,
	input  logic                  empty,
	output logic                  pop,
	input  logic [`KEY_COUNT-1:0] key_level,
	input  logic [`KEY_COUNT-1:0] key_press,
	output logic [7:0]            seg_number,
	output logic [7:0]            seg_choice,
	output logic [7:0]            led
);
	import board_pkg::*;

	localparam int DCNT_W = $clog2(`DIGIT_CYCLES + 1);

	logic [DCNT_W-1:0] dig_cnt;
	logic [2:0]        digit_idx;
	logic              frame_end;
	disp_word_u        status;
	disp_word_u        status_next;
	disp_word_u        shown;

	// active low segments {dp,g,f,e,d,c,b,a}, dp kept dark
	function automatic logic [7:0] hex_to_seg(input logic [3:0] nib);
		logic [7:0] seg;
		case (nib)
			4'h0: seg = 8'hc0;
			4'h1: seg = 8'hf9;
			4'h2: seg = 8'ha4;
			4'h3: seg = 8'hb0;
			4'h4: seg = 8'h99;
			4'h5: seg = 8'h92;
			4'h6: seg = 8'h82;
			4'h7: seg = 8'hf8;
			4'h8: seg = 8'h80;
			4'h9: seg = 8'h90;
			4'ha: seg = 8'h88;
			4'hb: seg = 8'h83;
			4'hc: seg = 8'hc6;
			4'hd: seg = 8'ha1;
			4'he: seg = 8'h86;
			default: seg = 8'h8e;
		endcase
		return seg;
	endfunction

	// last cycle of digit 7
	assign frame_end = (digit_idx == 3'd7) && (dig_cnt == DCNT_W'(`DIGIT_CYCLES - 1));

	// one record per frame, none while frozen
	assign pop = frame_end & ~empty & ~key_level[`KEY_FREEZE];

	// scan timer
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dig_cnt   <= '0;
			digit_idx <= '0;
		end else if (dig_cnt == DCNT_W'(`DIGIT_CYCLES - 1)) begin
			dig_cnt   <= '0;
			digit_idx <= digit_idx + 1'b1;
		end else begin
			dig_cnt <= dig_cnt + 1'b1;
		end
	end

	// clear first, then a same-cycle pop lands on the cleared word
	always_comb begin
		status_next = status;
		if (key_press[`KEY_CLEAR])
			status_next = '0;
		if (pop) begin
			status_next.bytes.rx_count  = status_next.bytes.rx_count + 8'd1;
			status_next.bytes.err_count = status_next.bytes.err_count + 8'(head.frame_err);
			status_next.bytes.prev_byte = status_next.bytes.last_byte;
			status_next.bytes.last_byte = head.data;
		end
	end

	// shown word only changes between frames
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			status <= '0;
			shown  <= '0;
		end else begin
			status <= status_next;
			if (frame_end)
				shown <= status_next;
		end
	end

	// digit k shows nibble k
	assign seg_number = hex_to_seg(shown.nib[digit_idx]);
	assign seg_choice = ~(8'd1 << digit_idx);
	assign led        = status.bytes.last_byte;

endmodule

`default_nettype wire

//--- design/uart_rx.sv
// uart receiver without oversampling
// two-flop synchronizer, bit timer and idle/start/data/stop fsm
`timescale 1ns/1ns
`default_nettype none
`include "board_defines.svh"

module uart_rx (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                rx_line,
	output board_pkg::rx_byte_t rx_byte,
	output logic                rx_valid
);
	import board_pkg::*;

	localparam int CNT_W = $clog2(`BIT_CYCLES);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic [CNT_W-1:0] cyc_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;
	logic             half_bit;
	logic             full_bit;

	// half a bit from the edge, then one bit per sample
	assign half_bit = (cyc_cnt == CNT_W'(`BIT_CYCLES / 2 - 1));
	assign full_bit = (cyc_cnt == CNT_W'(`BIT_CYCLES - 1));

	// line idles high, so reset to ones
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= st_idle;
			cyc_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					cyc_cnt <= '0;
					bit_idx <= '0;
					// falling edge starts the frame
					if (rx_prev && !rx_sync)
						state <= st_start;
				end
				st_start: begin
					if (half_bit) begin
						cyc_cnt <= '0;
						// line back high means a glitch
						state   <= rx_sync ? st_idle : st_data;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				st_data: begin
					if (full_bit) begin
						cyc_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default: begin
					// stop bit middle, strobe out next cycle
					if (full_bit) begin
						cyc_cnt  <= '0;
						rx_valid <= 1'b1;
						state    <= st_idle;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// payload, lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == st_data && full_bit)
			shift_reg <= {rx_sync, shift_reg[7:1]};
		// low stop bit flags a framing error
		if (state == st_stop && full_bit)
			rx_byte <= rx_byte_t'{data: shift_reg, frame_err: ~rx_sync};
	end

endmodule

`default_nettype wire

//--- test/board_tb.sv
// testbench for the board top level
// uart and key stimulus, segment decoding monitor
// reference status model, compare tasks and watchdog
`timescale 1ns/1ns
`default_nettype none
`include "board_defines.svh"

module board_tb;
	import board_pkg::*;

	localparam int CLK_NS       = 8;
	// start, eight data, stop and one idle bit
	localparam int BYTE_NS      = 11 * `BIT_CYCLES * CLK_NS;
	// bytes sent over all tests
	localparam int TEST_BYTES   = 4 + 3 + 8 + 2;
	localparam int WATCHDOG_NS  = (3 * TEST_BYTES + 20) * BYTE_NS;
	localparam int CHECK_FRAMES = 12;
	localparam int KEY_HOLD     = `DEBOUNCE_CYCLES + 8;

	// logged byte or clear press
	typedef struct packed {
		logic     clear;
		rx_byte_t rec;
	} ev_t;

	logic                  sys_clk;
	logic                  sys_rst_n;
	logic                  uart_rx_port;
	logic [`KEY_COUNT-1:0] key_in;
	logic [7:0]            seg_number;
	logic [7:0]            seg_choice;
	logic [7:0]            led;

	int              seed = 88861;
	int              errors;
	int              checks;
	int              tests;
	int              test_err;
	ev_t             ev_log [0:63];
	int              ev_n;
	disp_word_u      shown_word;
	disp_word_u      exp_word;
	logic [7:0]      exp_led;
	event            frame_done;
	event            check_req;
	event            check_done;
	// monitor state
	logic [7:0]      prev_choice;
	int              same_cnt;
	logic [7:0]      seen;
	logic [7:0][3:0] nib_acc;

	board_top dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.key_in       (key_in),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.led          (led)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	// watchdog sized from the byte count of all tests
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	// expected status after the first n logged events
	function automatic disp_word_u ref_status(input int n);
		disp_word_u w;
		int         i;
		w = '0;
		for (i = 0; i < n; i++) begin
			if (ev_log[i].clear) begin
				w = '0;
			end else begin
				// both counters wrap at 256
				w.bytes.rx_count = w.bytes.rx_count + 8'd1;
				if (ev_log[i].rec.frame_err)
					w.bytes.err_count = w.bytes.err_count + 8'd1;
				w.bytes.prev_byte = w.bytes.last_byte;
				w.bytes.last_byte = ev_log[i].rec.data;
			end
		end
		return w;
	endfunction

	// active low segments back to a nibble
	// bit 4 marks a known pattern
	function automatic logic [4:0] seg_to_nib(input logic [7:0] seg);
		logic [4:0] r;
		case (seg)
			8'hc0: r = 5'h10;
			8'hf9: r = 5'h11;
			8'ha4: r = 5'h12;
			8'hb0: r = 5'h13;
			8'h99: r = 5'h14;
			8'h92: r = 5'h15;
			8'h82: r = 5'h16;
			8'hf8: r = 5'h17;
			8'h80: r = 5'h18;
			8'h90: r = 5'h19;
			8'h88: r = 5'h1a;
			8'h83: r = 5'h1b;
			8'hc6: r = 5'h1c;
			8'ha1: r = 5'h1d;
			8'h86: r = 5'h1e;
			8'h8e: r = 5'h1f;
			default: r = 5'h00;
		endcase
		return r;
	endfunction

	// digit picked by one low bit
	// -1 for anything else
	function automatic int choice_to_digit(input logic [7:0] choice);
		int d;
		int i;
		d = -1;
		for (i = 0; i < 8; i++)
			if (choice === ~(8'd1 << i))
				d = i;
		return d;
	endfunction

	task automatic check_word(input string name, input disp_word_u exp,
			input disp_word_u act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %0t ns %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_led(input string name, input logic [7:0] exp,
			input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %0t ns %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// start bit, lsb first, stop bit, then one idle bit
	task automatic send_rec(input logic [7:0] data, input logic bad_stop);
		int i;
		@(posedge sys_clk);
		uart_rx_port <= 1'b0;
		repeat (`BIT_CYCLES) @(posedge sys_clk);
		for (i = 0; i < 8; i++) begin
			uart_rx_port <= data[i];
			repeat (`BIT_CYCLES) @(posedge sys_clk);
		end
		uart_rx_port <= ~bad_stop;
		repeat (`BIT_CYCLES) @(posedge sys_clk);
		uart_rx_port <= 1'b1;
		repeat (`BIT_CYCLES) @(posedge sys_clk);
		ev_log[ev_n].clear         = 1'b0;
		ev_log[ev_n].rec.data      = data;
		ev_log[ev_n].rec.frame_err = bad_stop;
		ev_n++;
	endtask

	// active low key held past the debounce time
	task automatic set_key(input int idx, input logic pressed);
		@(posedge sys_clk);
		key_in[idx] <= ~pressed;
		repeat (KEY_HOLD) @(posedge sys_clk);
	endtask

	task automatic expect_display(input int n);
		exp_word = ref_status(n);
		exp_led  = exp_word.bytes.last_byte;
		-> check_req;
		@(check_done);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s done with %0d errors", tests, name, errors - test_err);
		test_err = errors;
	endtask

	// mid-digit sampling on the falling edge
	// one word per full frame
	always @(negedge sys_clk) begin
		int         dig;
		logic [4:0] dec;
		if (!sys_rst_n) begin
			prev_choice = 8'hff;
			same_cnt    = 0;
			seen        = '0;
		end else begin
			same_cnt    = (seg_choice === prev_choice) ? same_cnt + 1 : 0;
			prev_choice = seg_choice;
			if (same_cnt == `DIGIT_CYCLES / 2) begin
				dig = choice_to_digit(seg_choice);
				dec = seg_to_nib(seg_number);
				if (dig < 0) begin
					errors++;
					$display("digit select %b at %0t ns does not pick one digit",
						seg_choice, $time);
				end else if (!dec[4]) begin
					errors++;
					$display("digit %0d at %0t ns shows undecodable segments %h",
						dig, $time, seg_number);
				end else begin
					nib_acc[dig] = dec[3:0];
					seen[dig]    = 1'b1;
					// digit 7 closes the frame
					if (dig == 7) begin
						if (seen == 8'hff) begin
							shown_word.nib = nib_acc;
							-> frame_done;
						end
						seen = '0;
					end
				end
			end
		end
	end

	// compare process
	// waits for the word to settle or times out
	initial begin
		int waited;
		forever begin
			@(check_req);
			waited = 0;
			@(frame_done);
			while (shown_word !== exp_word && waited < CHECK_FRAMES) begin
				@(frame_done);
				waited++;
			end
			check_word("display word", exp_word, shown_word);
			check_led("led", exp_led, led);
			-> check_done;
		end
	end

	initial begin
		logic [7:0] b;
		int         i;
		int         n;
		int         base_n;
		int         waited;
		disp_word_u base_word;
		sys_rst_n    = 1'b0;
		uart_rx_port = 1'b1;
		key_in       = '1;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		test_err     = 0;
		ev_n         = 0;
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		expect_display(0);
		end_test("reset state");

		for (i = 0; i < 4; i++) begin
			b = 8'($random(seed));
			send_rec(b, 1'b0);
			expect_display(ev_n);
		end
		end_test("single bytes");

		// first and last with a low stop bit
		for (i = 0; i < 3; i++) begin
			b = 8'($random(seed));
			send_rec(b, i != 1);
			expect_display(ev_n);
		end
		end_test("frame errors");

		// burst waits in the fifo while frozen
		base_n = ev_n;
		set_key(`KEY_FREEZE, 1'b1);
		n = 1 + ($random(seed) & 7);
		for (i = 0; i < n; i++) begin
			b = 8'($random(seed));
			send_rec(b, 1'b0);
		end
		expect_display(base_n);
		base_word = ref_status(base_n);
		set_key(`KEY_FREEZE, 1'b0);
		waited = 0;
		@(frame_done);
		while (shown_word === base_word && waited < CHECK_FRAMES) begin
			@(frame_done);
			waited++;
		end
		if (shown_word === base_word) begin
			errors++;
			$display("display stayed frozen after key 1 was released");
		end
		// one byte per frame from here on
		for (i = 1; i <= n; i++) begin
			if (i > 1)
				@(frame_done);
			check_word("display word", ref_status(base_n + i), shown_word);
		end
		exp_word = ref_status(ev_n);
		check_led("led", exp_word.bytes.last_byte, led);
		end_test("freeze burst");

		set_key(`KEY_CLEAR, 1'b1);
		set_key(`KEY_CLEAR, 1'b0);
		ev_log[ev_n].clear = 1'b1;
		ev_log[ev_n].rec   = '0;
		ev_n++;
		expect_display(ev_n);
		for (i = 0; i < 2; i++) begin
			b = 8'($random(seed));
			send_rec(b, 1'b0);
			expect_display(ev_n);
		end
		end_test("clear");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
